// File: build.f
+incdir+tests
verilog/fsab_mem_pkg.sv
verilog/mem_bank.sv
verilog/fsab_inbound.sv
verilog/fsab_response.sv
verilog/fsab_mem.sv
tests/tb_fsab_mem.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fsab_mem \
	-f build.f -o tb_fsab_mem > build.log 2>&1 \
	&& ./obj_dir/tb_fsab_mem > sim.log 2>&1 \
	|| echo "build or simulation error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q '\*\*\* PASSED \*\*\*' sim.log 2>/dev/null && exit 0 || exit 1

// File: tests/tb_fsab_tests.svh
// Nothing moves on either bus without traffic
task automatic idle_after_reset();
	int err_start;
	err_start = errors;
	repeat (10) begin
		@(negedge clk);
		compare("fsabo_credit", fsabo_credit, 1'b0);
		compare("fsabi_valid", fsabi_valid, 1'b0);
	end
	@(posedge clk);
	#1;
	report_test("idle_after_reset", err_start);
endtask

// Every word gets a value derived from its own address
task automatic preload_mem();
	for (int w = 0; w < MEM_WORDS; w += fsab_mem_pkg::FSAB_LEN_MAX) begin
		for (int i = 0; i < fsab_mem_pkg::FSAB_LEN_MAX; i++) begin
			wbuf_data[i] = {~32'(w + i), 32'(w + i) ^ 32'h5a5a_0000};
			wbuf_mask[i] = '1;
		end
		write_burst(4'h0, 4'h0, w, fsab_mem_pkg::FSAB_LEN_MAX);
	end
	wait_credits();
endtask

task automatic single_write_read();
	int err_start;
	err_start = errors;
	wbuf_data[0] = 64'h0123_4567_89ab_cdef;
	wbuf_mask[0] = 8'hff;
	write_burst(4'h3, 4'h1, 37, 1);
	read_burst(4'h9, 4'h6, 37, 1);
	drain_reads();
	wait_credits();
	report_test("single_write_read", err_start);
endtask

task automatic masked_burst_merge();
	int err_start;
	err_start = errors;
	for (int i = 0; i < 8; i++) begin
		wbuf_data[i] = {$random(seed), $random(seed)};
		wbuf_mask[i] = fsab_mem_pkg::fsab_mask_t'($random(seed));
	end
	write_burst(4'h2, 4'h4, 64, 8);     // Two passes over banks 0 to 3
	read_burst(4'h5, 4'ha, 64, 8);
	drain_reads();
	wait_credits();
	report_test("masked_burst_merge", err_start);
endtask

task automatic ordered_reads();
	int err_start;
	err_start = errors;
	read_burst(4'h1, 4'h8, 3, 1);
	read_burst(4'h2, 4'h9, 100, 3);
	read_burst(4'h3, 4'ha, 250, 8);     // Wraps past the top word
	read_burst(4'h4, 4'hb, 17, 2);
	drain_reads();
	wait_credits();
	report_test("ordered_reads", err_start);
endtask

task automatic credit_accounting();
	int err_start;
	int pulses;
	err_start = errors;
	wait_credits();
	pulses = credit_pulses;
	wbuf_data[0] = 64'hfeed_0000_0000_0001;
	wbuf_data[1] = 64'hfeed_0000_0000_0002;
	wbuf_mask[0] = 8'hff;
	wbuf_mask[1] = 8'h0f;
	write_burst(4'h6, 4'h0, 120, 2);
	read_burst(4'h6, 4'h1, 120, 2);
	write_burst(4'h6, 4'h2, 122, 1);
	read_burst(4'h6, 4'h3, 119, 4);
	compare("master credits", credits, 0);
	wait_credits();
	compare("fsabo_credit pulses", credit_pulses - pulses, 4);
	read_burst(4'h7, 4'h4, 120, 4);     // Fifth request, on a returned credit
	drain_reads();
	wait_credits();
	compare("fsabo_credit pulses", credit_pulses - pulses, 5);
	report_test("credit_accounting", err_start);
endtask

task automatic random_traffic();
	int err_start;
	int w;
	int len;
	err_start = errors;
	for (int n = 0; n < 20; n++) begin
		w   = $random(seed) & 32'hff;
		len = ($random(seed) & 32'h7) + 1;
		if (($random(seed) & 32'h1) != 0) begin
			for (int i = 0; i < len; i++) begin
				wbuf_data[i] = {$random(seed), $random(seed)};
				wbuf_mask[i] = fsab_mem_pkg::fsab_mask_t'($random(seed));
			end
			write_burst(4'(n), 4'hc, w, len);
		end else begin
			read_burst(4'(n), 4'hd, w, len);
		end
	end
	drain_reads();
	wait_credits();
	report_test("random_traffic", err_start);
endtask

// File: tests/tb_fsab_mem.sv
`timescale 1ns/100ps

module tb_fsab_mem;

	localparam int TIMEOUT   = 400;     // Cycles allowed per wait loop
	localparam int MEM_WORDS = fsab_mem_pkg::N_BANKS * fsab_mem_pkg::BANK_WORDS;

	logic                     clk;
	logic                     rst_b;
	logic                     fsabo_valid;
	fsab_mem_pkg::fsab_mode_e fsabo_mode;
	fsab_mem_pkg::fsab_did_t  fsabo_did;
	fsab_mem_pkg::fsab_did_t  fsabo_subdid;
	fsab_mem_pkg::fsab_addr_t fsabo_addr;
	fsab_mem_pkg::fsab_len_t  fsabo_len;
	fsab_mem_pkg::fsab_data_t fsabo_data;
	fsab_mem_pkg::fsab_mask_t fsabo_mask;
	logic                     fsabo_credit;
	logic                     fsabi_valid;
	fsab_mem_pkg::fsab_did_t  fsabi_did;
	fsab_mem_pkg::fsab_did_t  fsabi_subdid;
	fsab_mem_pkg::fsab_data_t fsabi_data;

	int     credits;            // Credits the master holds
	int     credit_pulses;
	int     cycle;
	int     errors;
	int     tests;
	integer seed;

	logic [7:0]               ref_mem [MEM_WORDS*8];    // Reference model, byte wide
	fsab_mem_pkg::fsab_data_t wbuf_data [fsab_mem_pkg::FSAB_LEN_MAX];
	fsab_mem_pkg::fsab_mask_t wbuf_mask [fsab_mem_pkg::FSAB_LEN_MAX];

	// Expected and observed read beats, tag is {did, subdid}
	fsab_mem_pkg::fsab_data_t exp_data [$];
	logic [7:0]               exp_tag [$];
	bit                       exp_first [$];
	fsab_mem_pkg::fsab_data_t got_data [$];
	logic [7:0]               got_tag [$];
	int                       got_cycle [$];

	fsab_mem UUT (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle++;
	end

	// Bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_b && fsabo_credit) begin
			credits++;
			credit_pulses++;
		end
		if (rst_b && fsabi_valid) begin
			got_data.push_back(fsabi_data);
			got_tag.push_back({fsabi_did, fsabi_subdid});
			got_cycle.push_back(cycle);
		end
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests++;
		$display("%-20s done, %0d errors", name, errors - err_start);
	endtask

	// Called at a slot start, 1 ns after the edge
	task automatic take_credit();
		int t;
		t = 0;
		while (credits <= 0 && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (credits <= 0) begin
			$display("timeout: no credit came back within %0d cycles", TIMEOUT);
			errors++;
		end
		credits--;
	endtask

	task automatic wait_credits();
		int t;
		t = 0;
		while (credits != fsab_mem_pkg::FSAB_CREDITS && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		if (credits != fsab_mem_pkg::FSAB_CREDITS) begin
			$display("timeout: only %0d credits back at the master", credits);
			errors++;
		end
	endtask

	function automatic fsab_mem_pkg::fsab_data_t ref_word(input int w);
		fsab_mem_pkg::fsab_data_t d;
		for (int j = 0; j < 8; j++) begin
			d[j*8 +: 8] = ref_mem[w*8 + j];
		end
		return d;
	endfunction

	// Beats come from wbuf_data and wbuf_mask
	task automatic write_burst(input fsab_mem_pkg::fsab_did_t did,
			input fsab_mem_pkg::fsab_did_t subdid, input int waddr, input int len);
		int w;
		take_credit();
		fsabo_mode   = fsab_mem_pkg::FSAB_WRITE;
		fsabo_did    = did;
		fsabo_subdid = subdid;
		fsabo_addr   = fsab_mem_pkg::fsab_addr_t'(waddr * 8);
		fsabo_len    = fsab_mem_pkg::fsab_len_t'(len);
		for (int i = 0; i < len; i++) begin
			w = (waddr + i) % MEM_WORDS;
			for (int j = 0; j < 8; j++) begin
				if (wbuf_mask[i][j]) begin
					ref_mem[w*8 + j] = wbuf_data[i][j*8 +: 8];
				end
			end
			fsabo_valid = 1'b1;
			fsabo_data  = wbuf_data[i];
			fsabo_mask  = wbuf_mask[i];
			@(posedge clk);
			#1;
		end
		fsabo_valid = 1'b0;
	endtask

	task automatic read_burst(input fsab_mem_pkg::fsab_did_t did,
			input fsab_mem_pkg::fsab_did_t subdid, input int waddr, input int len);
		take_credit();
		fsabo_valid  = 1'b1;
		fsabo_mode   = fsab_mem_pkg::FSAB_READ;
		fsabo_did    = did;
		fsabo_subdid = subdid;
		fsabo_addr   = fsab_mem_pkg::fsab_addr_t'(waddr * 8);
		fsabo_len    = fsab_mem_pkg::fsab_len_t'(len);
		fsabo_data   = '0;
		fsabo_mask   = '0;
		for (int i = 0; i < len; i++) begin
			exp_data.push_back(ref_word((waddr + i) % MEM_WORDS));
			exp_tag.push_back({did, subdid});
			exp_first.push_back(i == 0);
		end
		@(posedge clk);
		#1;
		fsabo_valid = 1'b0;
	endtask

	// Waits for every expected beat, then checks data, tag and burst contiguity
	task automatic drain_reads();
		int t;
		int prev;
		t = 0;
		prev = 0;
		while (got_data.size() < exp_data.size() && t < TIMEOUT) begin
			@(posedge clk);
			#1;
			t++;
		end
		repeat (4) begin
			@(posedge clk);
			#1;
		end
		if (got_data.size() != exp_data.size()) begin
			$display("read beat count wrong: %0d arrived, %0d expected",
				got_data.size(), exp_data.size());
			errors++;
		end
		while (got_data.size() > 0 && exp_data.size() > 0) begin
			if (!exp_first[0]) begin
				compare("fsabi_valid burst cycle", got_cycle[0], prev + 1);
			end
			prev = got_cycle.pop_front();
			compare("fsabi_data", got_data.pop_front(), exp_data.pop_front());
			compare("{fsabi_did,fsabi_subdid}", got_tag.pop_front(), exp_tag.pop_front());
			exp_first.delete(0);
		end
		exp_data.delete();
		exp_tag.delete();
		exp_first.delete();
		got_data.delete();
		got_tag.delete();
		got_cycle.delete();
	endtask

	`include "tb_fsab_tests.svh"

	initial begin
		seed          = 32'h824987db;
		errors        = 0;
		tests         = 0;
		cycle         = 0;
		credits       = fsab_mem_pkg::FSAB_CREDITS;
		credit_pulses = 0;
		rst_b         = 1'b0;
		fsabo_valid   = 1'b0;
		fsabo_mode    = fsab_mem_pkg::FSAB_READ;
		fsabo_did     = '0;
		fsabo_subdid  = '0;
		fsabo_addr    = '0;
		fsabo_len     = '0;
		fsabo_data    = '0;
		fsabo_mask    = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_b = 1'b1;
		idle_after_reset();
		preload_mem();
		single_write_read();
		masked_burst_merge();
		ordered_reads();
		credit_accounting();
		random_traffic();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: verilog/fsab_inbound.sv
`timescale 1ns/100ps

module fsab_inbound (
	input  logic                                clk,
	input  logic                                rst_b,
	input  logic                                fsabo_valid,
	input  fsab_mem_pkg::fsab_mode_e            fsabo_mode,
	input  fsab_mem_pkg::fsab_did_t             fsabo_did,
	input  fsab_mem_pkg::fsab_did_t             fsabo_subdid,
	input  fsab_mem_pkg::fsab_addr_t            fsabo_addr,
	input  fsab_mem_pkg::fsab_len_t             fsabo_len,
	input  fsab_mem_pkg::fsab_data_t            fsabo_data,
	input  fsab_mem_pkg::fsab_mask_t            fsabo_mask,
	output logic                                fsabo_credit,
	output logic [fsab_mem_pkg::N_BANKS-1:0]    bank_en,
	output logic                                bank_we,
	output fsab_mem_pkg::bank_idx_t             bank_idx [fsab_mem_pkg::N_BANKS],
	output fsab_mem_pkg::fsab_data_t            bank_wdata [fsab_mem_pkg::N_BANKS],
	output fsab_mem_pkg::fsab_mask_t            bank_wmask [fsab_mem_pkg::N_BANKS],
	output logic                                rd_issue,
	output fsab_mem_pkg::fsab_did_t             rd_did,
	output fsab_mem_pkg::fsab_did_t             rd_subdid,
	output logic                                rd_first
);

	// Request queue, one entry per credit
	fsab_mem_pkg::fsab_mode_e rq_mode [fsab_mem_pkg::FSAB_CREDITS];
	fsab_mem_pkg::fsab_did_t  rq_did [fsab_mem_pkg::FSAB_CREDITS];
	fsab_mem_pkg::fsab_did_t  rq_subdid [fsab_mem_pkg::FSAB_CREDITS];
	fsab_mem_pkg::fsab_addr_t rq_addr [fsab_mem_pkg::FSAB_CREDITS];
	fsab_mem_pkg::fsab_len_t  rq_len [fsab_mem_pkg::FSAB_CREDITS];
	logic [fsab_mem_pkg::REQ_PTR_W:0]   rq_wptr;
	logic [fsab_mem_pkg::REQ_PTR_W:0]   rq_rptr;
	logic [fsab_mem_pkg::REQ_PTR_W:0]   rq_fill;
	logic [fsab_mem_pkg::REQ_PTR_W-1:0] rq_head;
	logic                               rq_full;
	logic [fsab_mem_pkg::REQ_PTR_W:0]   req_cnt;      // Fully received, not yet popped

	// Data queue for write beats
	fsab_mem_pkg::fsab_data_t dq_data [fsab_mem_pkg::DATA_Q_DEPTH];
	fsab_mem_pkg::fsab_mask_t dq_mask [fsab_mem_pkg::DATA_Q_DEPTH];
	logic [fsab_mem_pkg::DATA_PTR_W-1:0] dq_wptr;
	logic [fsab_mem_pkg::DATA_PTR_W-1:0] dq_rptr;

	// Receive side
	fsab_mem_pkg::fsab_len_t beat_rem;     // Data beats still owed by the master
	logic                    hdr;
	logic                    data_wr;
	logic                    req_done;

	// Dispatcher
	fsab_mem_pkg::disp_state_e       state;
	fsab_mem_pkg::fsab_mode_e        cur_mode;
	fsab_mem_pkg::fsab_did_t         cur_did;
	fsab_mem_pkg::fsab_did_t         cur_subdid;
	logic [fsab_mem_pkg::WADDR_W-1:0] cur_waddr;
	fsab_mem_pkg::fsab_len_t         cur_rem;
	logic                            cur_first;
	logic                            issue;
	logic                            last_beat;
	logic                            pop;
	logic                            dq_pop;

	// Credit return
	logic       rd_last;
	logic       wr_last_d;
	logic [2:0] credit_pend;

	assign hdr     = fsabo_valid && beat_rem == '0;
	assign data_wr = fsabo_valid && (beat_rem != '0 || fsabo_mode == fsab_mem_pkg::FSAB_WRITE);
	assign req_done = (hdr && (fsabo_mode == fsab_mem_pkg::FSAB_READ ||
	                           fsabo_len == fsab_mem_pkg::fsab_len_t'(1))) ||
	                  (fsabo_valid && beat_rem == fsab_mem_pkg::fsab_len_t'(1));

	assign rq_fill = rq_wptr - rq_rptr;
	assign rq_full = rq_fill[fsab_mem_pkg::REQ_PTR_W];   // Depth is a power of two
	assign rq_head = rq_rptr[fsab_mem_pkg::REQ_PTR_W-1:0];

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beat_rem <= '0;
			rq_wptr  <= '0;
			dq_wptr  <= '0;
			req_cnt  <= '0;
		end else begin
			if (hdr && fsabo_mode == fsab_mem_pkg::FSAB_WRITE) begin
				beat_rem <= fsabo_len - 1'b1;     // Header beat carries word 0
			end else if (fsabo_valid && beat_rem != '0) begin
				beat_rem <= beat_rem - 1'b1;
			end
			if (hdr) begin
				rq_wptr <= rq_wptr + 1'b1;
			end
			if (data_wr) begin
				dq_wptr <= dq_wptr + 1'b1;
			end
			req_cnt <= req_cnt + req_done - pop;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr) begin
			rq_mode[rq_wptr[fsab_mem_pkg::REQ_PTR_W-1:0]]   <= fsabo_mode;
			rq_did[rq_wptr[fsab_mem_pkg::REQ_PTR_W-1:0]]    <= fsabo_did;
			rq_subdid[rq_wptr[fsab_mem_pkg::REQ_PTR_W-1:0]] <= fsabo_subdid;
			rq_addr[rq_wptr[fsab_mem_pkg::REQ_PTR_W-1:0]]   <= fsabo_addr;
			rq_len[rq_wptr[fsab_mem_pkg::REQ_PTR_W-1:0]]    <= fsabo_len;
		end
		if (data_wr) begin
			dq_data[dq_wptr] <= fsabo_data;
			dq_mask[dq_wptr] <= fsabo_mask;
		end
	end

	assign issue     = state == fsab_mem_pkg::DISP_BURST;
	assign last_beat = issue && cur_rem == fsab_mem_pkg::fsab_len_t'(1);
	assign pop       = req_cnt != '0 && (state == fsab_mem_pkg::DISP_IDLE || last_beat);
	assign dq_pop    = issue && cur_mode == fsab_mem_pkg::FSAB_WRITE;
	assign rd_last   = last_beat && cur_mode == fsab_mem_pkg::FSAB_READ;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state       <= fsab_mem_pkg::DISP_IDLE;
			cur_rem     <= '0;
			cur_first   <= 1'b0;
			rq_rptr     <= '0;
			dq_rptr     <= '0;
			wr_last_d   <= 1'b0;
			credit_pend <= '0;
		end else begin
			if (pop) begin
				state     <= fsab_mem_pkg::DISP_BURST;   // Back to back with no bubble
				cur_rem   <= rq_len[rq_head];
				cur_first <= 1'b1;
				rq_rptr   <= rq_rptr + 1'b1;
			end else begin
				if (last_beat) begin
					state <= fsab_mem_pkg::DISP_IDLE;
				end
				if (issue) begin
					cur_rem   <= cur_rem - 1'b1;
					cur_first <= 1'b0;
				end
			end
			if (dq_pop) begin
				dq_rptr <= dq_rptr + 1'b1;
			end
			wr_last_d   <= last_beat && cur_mode == fsab_mem_pkg::FSAB_WRITE;
			credit_pend <= credit_pend + rd_last + wr_last_d - fsabo_credit;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur_mode   <= rq_mode[rq_head];
			cur_did    <= rq_did[rq_head];
			cur_subdid <= rq_subdid[rq_head];
			cur_waddr  <= rq_addr[rq_head][fsab_mem_pkg::WORD_SHIFT +: fsab_mem_pkg::WADDR_W];
		end else if (issue) begin
			cur_waddr <= cur_waddr + 1'b1;        // Next word lands in the next bank
		end
	end

	// A write-then-read pair can finish in one cycle; the extra credit waits a cycle
	assign fsabo_credit = rd_last || wr_last_d || credit_pend != '0;

	always_comb begin
		bank_en = '0;
		if (issue) begin
			bank_en[cur_waddr[fsab_mem_pkg::BANK_SEL_W-1:0]] = 1'b1;
		end
		for (int b = 0; b < fsab_mem_pkg::N_BANKS; b++) begin
			bank_idx[b]   = cur_waddr[fsab_mem_pkg::WADDR_W-1:fsab_mem_pkg::BANK_SEL_W];
			bank_wdata[b] = dq_data[dq_rptr];
			bank_wmask[b] = dq_mask[dq_rptr];
		end
	end

	assign bank_we   = cur_mode == fsab_mem_pkg::FSAB_WRITE;
	assign rd_issue  = issue && cur_mode == fsab_mem_pkg::FSAB_READ;
	assign rd_did    = cur_did;
	assign rd_subdid = cur_subdid;
	assign rd_first  = cur_first;

	// Master must never exceed its credits
	hdr_room: assert property (@(posedge clk) disable iff (!rst_b)
		hdr |-> !rq_full)
		else $error("fsab_inbound: header with request queue full");

	bank_one_hot: assert property (@(posedge clk) disable iff (!rst_b)
		$onehot0(bank_en))
		else $error("fsab_inbound: more than one bank enabled");

endmodule

// File: verilog/fsab_mem.sv
`timescale 1ns/100ps

module fsab_mem (
	input  logic                     clk,
	input  logic                     rst_b,
	input  logic                     fsabo_valid,
	input  fsab_mem_pkg::fsab_mode_e fsabo_mode,
	input  fsab_mem_pkg::fsab_did_t  fsabo_did,
	input  fsab_mem_pkg::fsab_did_t  fsabo_subdid,
	input  fsab_mem_pkg::fsab_addr_t fsabo_addr,
	input  fsab_mem_pkg::fsab_len_t  fsabo_len,
	input  fsab_mem_pkg::fsab_data_t fsabo_data,
	input  fsab_mem_pkg::fsab_mask_t fsabo_mask,
	output logic                     fsabo_credit,
	output logic                     fsabi_valid,
	output fsab_mem_pkg::fsab_did_t  fsabi_did,
	output fsab_mem_pkg::fsab_did_t  fsabi_subdid,
	output fsab_mem_pkg::fsab_data_t fsabi_data
);

	// Dispatcher to banks
	logic [fsab_mem_pkg::N_BANKS-1:0] bank_en;
	logic                             bank_we;
	fsab_mem_pkg::bank_idx_t          bank_idx [fsab_mem_pkg::N_BANKS];
	fsab_mem_pkg::fsab_data_t         bank_wdata [fsab_mem_pkg::N_BANKS];
	fsab_mem_pkg::fsab_mask_t         bank_wmask [fsab_mem_pkg::N_BANKS];

	// Banks to response stage
	logic [fsab_mem_pkg::N_BANKS-1:0] rd_valid;
	fsab_mem_pkg::fsab_data_t         rd_data [fsab_mem_pkg::N_BANKS];

	// Read tags
	logic                    rd_issue;
	fsab_mem_pkg::fsab_did_t rd_did;
	fsab_mem_pkg::fsab_did_t rd_subdid;
	logic                    rd_first;

	fsab_inbound u_inbound (
		.clk          (clk),
		.rst_b        (rst_b),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.bank_en      (bank_en),
		.bank_we      (bank_we),
		.bank_idx     (bank_idx),
		.bank_wdata   (bank_wdata),
		.bank_wmask   (bank_wmask),
		.rd_issue     (rd_issue),
		.rd_did       (rd_did),
		.rd_subdid    (rd_subdid),
		.rd_first     (rd_first)
	);

	// Word-interleaved banks
	for (genvar b = 0; b < fsab_mem_pkg::N_BANKS; b++) begin : g_bank
		mem_bank u_bank (
			.clk      (clk),
			.rst_b    (rst_b),
			.en       (bank_en[b]),
			.we       (bank_we),
			.idx      (bank_idx[b]),
			.wdata    (bank_wdata[b]),
			.wmask    (bank_wmask[b]),
			.rd_valid (rd_valid[b]),
			.rd_data  (rd_data[b])
		);
	end

	fsab_response u_response (
		.clk          (clk),
		.rst_b        (rst_b),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.rd_issue     (rd_issue),
		.rd_did       (rd_did),
		.rd_subdid    (rd_subdid),
		.rd_first     (rd_first),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

endmodule

// File: verilog/fsab_mem_pkg.sv
package fsab_mem_pkg;

	// FSAB field widths
	localparam int FSAB_DATA_W  = 64;
	localparam int FSAB_MASK_W  = FSAB_DATA_W / 8;    // One enable per byte
	localparam int FSAB_ADDR_W  = 32;
	localparam int FSAB_LEN_W   = 4;
	localparam int FSAB_LEN_MAX = 8;                  // Longest burst in beats
	localparam int FSAB_DID_W   = 4;                  // Shared by did and subdid

	// Credits handed to the master out of reset
	localparam int FSAB_CREDITS = 4;
	localparam int DATA_Q_DEPTH = FSAB_CREDITS * FSAB_LEN_MAX;

	// Queue pointer widths
	localparam int REQ_PTR_W  = $clog2(FSAB_CREDITS);
	localparam int DATA_PTR_W = $clog2(DATA_Q_DEPTH);

	// Bank geometry
	localparam int N_BANKS    = 4;
	localparam int BANK_SEL_W = $clog2(N_BANKS);
	localparam int BANK_WORDS = 64;
	localparam int BANK_IDX_W = $clog2(BANK_WORDS);

	// Byte address to word address
	localparam int WORD_SHIFT = $clog2(FSAB_MASK_W);
	localparam int WADDR_W    = BANK_SEL_W + BANK_IDX_W;   // Bank in the low bits

	typedef logic [FSAB_DATA_W-1:0] fsab_data_t;
	typedef logic [FSAB_MASK_W-1:0] fsab_mask_t;
	typedef logic [FSAB_ADDR_W-1:0] fsab_addr_t;
	typedef logic [FSAB_LEN_W-1:0]  fsab_len_t;
	typedef logic [FSAB_DID_W-1:0]  fsab_did_t;
	typedef logic [BANK_IDX_W-1:0]  bank_idx_t;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	// Dispatcher states
	typedef enum logic {
		DISP_IDLE  = 1'b0,
		DISP_BURST = 1'b1
	} disp_state_e;

endpackage

// File: verilog/fsab_response.sv
`timescale 1ns/100ps

module fsab_response (
	input  logic                             clk,
	input  logic                             rst_b,
	input  logic [fsab_mem_pkg::N_BANKS-1:0] rd_valid,
	input  fsab_mem_pkg::fsab_data_t         rd_data [fsab_mem_pkg::N_BANKS],
	input  logic                             rd_issue,
	input  fsab_mem_pkg::fsab_did_t          rd_did,
	input  fsab_mem_pkg::fsab_did_t          rd_subdid,
	input  logic                             rd_first,
	output logic                             fsabi_valid,
	output fsab_mem_pkg::fsab_did_t          fsabi_did,
	output fsab_mem_pkg::fsab_did_t          fsabi_subdid,
	output fsab_mem_pkg::fsab_data_t         fsabi_data
);

	// Issue tags one cycle late, in step with the bank read port
	logic                    iss_d;
	logic                    first_d;
	fsab_mem_pkg::fsab_did_t did_d;
	fsab_mem_pkg::fsab_did_t subdid_d;

	// Bank data select
	logic                     any_valid;
	fsab_mem_pkg::fsab_data_t sel_data;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			iss_d   <= 1'b0;
			first_d <= 1'b0;
		end else begin
			iss_d   <= rd_issue;
			first_d <= rd_issue && rd_first;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_issue && rd_first) begin
			did_d    <= rd_did;         // Only the opening beat carries a new tag
			subdid_d <= rd_subdid;
		end
	end

	assign any_valid = |rd_valid;

	// OR-mux, at most one bank answers per cycle
	always_comb begin
		sel_data = '0;
		for (int b = 0; b < fsab_mem_pkg::N_BANKS; b++) begin
			if (rd_valid[b]) begin
				sel_data = sel_data | rd_data[b];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			fsabi_valid <= 1'b0;
		end else begin
			fsabi_valid <= any_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (any_valid) begin
			fsabi_data <= sel_data;
		end
		// Tag stays put until the next burst opens
		if (first_d) begin
			fsabi_did    <= did_d;
			fsabi_subdid <= subdid_d;
		end
	end

	one_bank: assert property (@(posedge clk) disable iff (!rst_b)
		$onehot0(rd_valid))
		else $error("fsab_response: several banks answered at once");

	// Each bank strobe must line up with a delayed read issue
	issue_match: assert property (@(posedge clk) disable iff (!rst_b)
		any_valid == iss_d)
		else $error("fsab_response: bank data out of step with issue");

endmodule

// File: verilog/mem_bank.sv
`timescale 1ns/100ps

module mem_bank (
	input  logic                     clk,
	input  logic                     rst_b,
	input  logic                     en,
	input  logic                     we,
	input  fsab_mem_pkg::bank_idx_t  idx,
	input  fsab_mem_pkg::fsab_data_t wdata,
	input  fsab_mem_pkg::fsab_mask_t wmask,
	output logic                     rd_valid,
	output fsab_mem_pkg::fsab_data_t rd_data
);

	fsab_mem_pkg::fsab_data_t mem [fsab_mem_pkg::BANK_WORDS];

	logic wr_en;
	logic rd_en;

	assign wr_en = en && we;
	assign rd_en = en && !we;

	// Byte lanes follow the mask, untouched lanes keep their old contents
	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int i = 0; i < fsab_mem_pkg::FSAB_MASK_W; i++) begin
				if (wmask[i]) begin
					mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[idx];
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_en;      // Single-cycle strobe per read
		end
	end

endmodule
